// File: source/dcache_pkg.sv
// Shared sizes, FSM state codes and the address view for the data cache RTL
`default_nettype none

package dcache_pkg;

    // Processor word address and data word
    localparam int addr_bits = 19;
    localparam int data_bits = 16;
    localparam int bytesel_bits = data_bits / 8;

    // Cache geometry, kept small for simulation
    localparam int num_lines = 64;
    localparam int line_words = 8;

    // Address split, tag takes whatever the index and offset leave
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits = addr_bits - index_bits - offset_bits;

    // Word address into the line data store
    localparam int line_addr_bits = index_bits + offset_bits;

    // Controller FSM encoding
    localparam int state_bits = 3;
    localparam logic [state_bits-1:0] st_idle = 3'd0;
    localparam logic [state_bits-1:0] st_lookup = 3'd1;
    localparam logic [state_bits-1:0] st_compare = 3'd2;
    localparam logic [state_bits-1:0] st_write_back = 3'd3;
    localparam logic [state_bits-1:0] st_fill = 3'd4;
    localparam logic [state_bits-1:0] st_done = 3'd5;

    // Field view of a word address, most significant field first
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [index_bits-1:0] index;
        logic [offset_bits-1:0] offset;
    } cache_addr_fields_t;

    // One address word, read flat or split into its fields
    typedef union packed {
        logic [addr_bits-1:0] word;
        cache_addr_fields_t fields;
    } cache_addr_t;

endpackage

`default_nettype wire

// File: source/dcache_line_ram.sv
// Line data store for the data cache with a processor port and a burst port
`default_nettype none
`timescale 1ns/1ps

module dcache_line_ram (
    input wire logic clk,

    // Processor side with byte-masked writes
    input wire logic [dcache_pkg::line_addr_bits-1:0] addr_a,
    input wire logic [dcache_pkg::data_bits-1:0] wdata_a,
    input wire logic [dcache_pkg::bytesel_bits-1:0] bytesel_a,
    input wire logic wr_en_a,
    output logic [dcache_pkg::data_bits-1:0] rdata_a,

    // Burst side for whole-word fill writes and write-back reads
    input wire logic [dcache_pkg::line_addr_bits-1:0] addr_b,
    input wire logic [dcache_pkg::data_bits-1:0] wdata_b,
    input wire logic wr_en_b,
    output logic [dcache_pkg::data_bits-1:0] rdata_b
);

    localparam int depth = dcache_pkg::num_lines * dcache_pkg::line_words;

    // One word per line slot, addressed by index then offset
    logic [dcache_pkg::data_bits-1:0] mem [depth];

    // Both ports in one process
    // Port b is written last, so it wins if both hit the same word
    always_ff @(posedge clk) begin
        if (wr_en_a) begin
            for (int b = 0; b < dcache_pkg::bytesel_bits; b++) begin
                if (bytesel_a[b]) begin
                    mem[addr_a][b*8 +: 8] <= wdata_a[b*8 +: 8];
                end
            end
        end
        if (wr_en_b) begin
            mem[addr_b] <= wdata_b;
        end

        // One cycle read latency with old data on a same-cycle write
        rdata_a <= mem[addr_a];
        rdata_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

// File: source/dcache_tag_store.sv
// Tag, valid and dirty storage per line with a registered lookup and hit compare
`default_nettype none
`timescale 1ns/1ps

module dcache_tag_store (
    input wire logic clk,
    input wire logic reset,

    // Processor address, sampled every cycle
    input wire dcache_pkg::cache_addr_t lookup_addr,

    // Line being replaced by the controller
    input wire logic [dcache_pkg::index_bits-1:0] update_addr,
    input wire logic tag_wr,
    input wire logic [dcache_pkg::tag_bits-1:0] tag_data,
    input wire logic valid_set,
    input wire logic dirty_clear,

    // Write hits mark their own line
    input wire logic [dcache_pkg::index_bits-1:0] dirty_set_index,
    input wire logic dirty_set,

    // Lookup result, one cycle after the address
    output logic hit,
    output logic [dcache_pkg::tag_bits-1:0] victim_tag,
    output logic victim_dirty
);

    logic [dcache_pkg::tag_bits-1:0] tags [dcache_pkg::num_lines];
    logic [dcache_pkg::num_lines-1:0] valid;
    logic [dcache_pkg::num_lines-1:0] dirty;

    // Registered entry and the tag it is compared against
    logic [dcache_pkg::tag_bits-1:0] entry_tag;
    logic [dcache_pkg::tag_bits-1:0] req_tag;
    logic entry_valid;
    logic entry_dirty;

    // Tag array and lookup registers
    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tags[update_addr] <= tag_data;
        end
        entry_tag <= tags[lookup_addr.fields.index];
        req_tag <= lookup_addr.fields.tag;
    end

    // Flag arrays, all lines start invalid and clean
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            entry_valid <= 1'b0;
            entry_dirty <= 1'b0;
        end else begin
            // New tag leaves the line invalid until the fill ends
            if (tag_wr) begin
                valid[update_addr] <= 1'b0;
            end
            if (valid_set) begin
                valid[update_addr] <= 1'b1;
            end
            if (dirty_clear) begin
                dirty[update_addr] <= 1'b0;
            end
            if (dirty_set) begin
                dirty[dirty_set_index] <= 1'b1;
            end
            entry_valid <= valid[lookup_addr.fields.index];
            entry_dirty <= dirty[lookup_addr.fields.index];
        end
    end

    assign hit = entry_valid && (entry_tag == req_tag);

    // Victim tag rebuilds the write-back address
    assign victim_tag = entry_tag;
    assign victim_dirty = entry_valid && entry_dirty;

endmodule

`default_nettype wire

// File: source/dcache_word_counter.sv
// Burst position counter for line transfers, flags the final word of a line
`default_nettype none
`timescale 1ns/1ps

module dcache_word_counter (
    input wire logic clk,
    input wire logic reset,
    input wire logic count_clear,
    input wire logic count_step,
    output logic [dcache_pkg::offset_bits-1:0] word_index,
    output logic last_word
);

    localparam logic [dcache_pkg::offset_bits-1:0] last_index =
        dcache_pkg::offset_bits'(dcache_pkg::line_words - 1);

    // Steps once per memory ack
    // Eight steps wrap it back to zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word_index <= '0;
        end else if (count_clear) begin
            word_index <= '0;
        end else if (count_step) begin
            word_index <= word_index + dcache_pkg::offset_bits'(1);
        end
    end

    // Controller tests this, never the count itself
    assign last_word = (word_index == last_index);

endmodule

`default_nettype wire

// File: source/dcache_controller.sv
// Data cache FSM, sequences lookup, write-back, fill and the processor ack
`default_nettype none
`timescale 1ns/1ps

module dcache_controller (
    input wire logic clk,
    input wire logic reset,
    input wire logic enabled,

    // Processor request
    input wire logic c_access,
    input wire logic c_wr_en,
    input wire dcache_pkg::cache_addr_t c_addr,

    // Tag store result
    input wire logic hit,
    input wire logic [dcache_pkg::tag_bits-1:0] victim_tag,
    input wire logic victim_dirty,

    // Memory handshake
    input wire logic m_ack,

    // Burst counter
    input wire logic last_word,
    input wire logic [dcache_pkg::offset_bits-1:0] word_index,
    output logic count_clear,
    output logic count_step,

    // Tag store updates
    output logic tag_wr,
    output logic valid_set,
    output logic dirty_set,
    output logic dirty_clear,

    // Line store control
    output logic line_wr_en_a,
    output logic line_wr_en_b,
    output logic [dcache_pkg::line_addr_bits-1:0] line_addr_b,

    // Memory burst request
    output logic [dcache_pkg::addr_bits-1:0] burst_addr,
    output logic burst_access,
    output logic burst_write,

    // Processor ack, one cycle
    output logic ack
);

    logic [dcache_pkg::state_bits-1:0] state;
    logic [dcache_pkg::state_bits-1:0] state_next;
    logic [dcache_pkg::offset_bits-1:0] next_word;
    logic [dcache_pkg::offset_bits-1:0] offset_b;
    dcache_pkg::cache_addr_t burst_u;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= dcache_pkg::st_idle;
            ack <= 1'b0;
        end else begin
            state <= state_next;
            // Compare cycle with a hit raises the ack, done holds it one cycle
            ack <= (state == dcache_pkg::st_compare) && hit;
        end
    end

    always_comb begin
        state_next = state;
        count_clear = 1'b0;
        count_step = 1'b0;
        tag_wr = 1'b0;
        valid_set = 1'b0;
        dirty_set = 1'b0;
        dirty_clear = 1'b0;
        line_wr_en_a = 1'b0;
        line_wr_en_b = 1'b0;
        case (state)
            dcache_pkg::st_idle: begin
                // Bypass keeps the FSM parked here
                if (enabled && c_access) begin
                    state_next = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_lookup: begin
                // Tag and data arrays read the processor address
                state_next = dcache_pkg::st_compare;
            end
            dcache_pkg::st_compare: begin
                count_clear = 1'b1;
                if (hit) begin
                    line_wr_en_a = c_wr_en;
                    dirty_set = c_wr_en;
                    state_next = dcache_pkg::st_done;
                end else if (victim_dirty) begin
                    state_next = dcache_pkg::st_write_back;
                end else begin
                    // Clean victim, claim the line and fetch
                    tag_wr = 1'b1;
                    dirty_clear = 1'b1;
                    state_next = dcache_pkg::st_fill;
                end
            end
            dcache_pkg::st_write_back: begin
                count_step = m_ack;
                if (m_ack && last_word) begin
                    tag_wr = 1'b1;
                    dirty_clear = 1'b1;
                    state_next = dcache_pkg::st_fill;
                end
            end
            dcache_pkg::st_fill: begin
                count_step = m_ack;
                line_wr_en_b = m_ack;
                // Line complete, retry the access as a hit
                if (m_ack && last_word) begin
                    valid_set = 1'b1;
                    state_next = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_done: begin
                // Request still up this cycle, so do not sample it
                state_next = dcache_pkg::st_idle;
            end
            default: begin
                state_next = dcache_pkg::st_idle;
            end
        endcase
    end

    // Write-back reads one word ahead to cover the RAM latency
    assign next_word = word_index + dcache_pkg::offset_bits'(1);
    assign offset_b = (state == dcache_pkg::st_write_back && m_ack) ? next_word : word_index;
    assign line_addr_b = {c_addr.fields.index, offset_b};

    // Victim tag for write-back, requested tag for fill
    always_comb begin
        burst_u.fields.tag = (state == dcache_pkg::st_write_back) ? victim_tag
                                                                   : c_addr.fields.tag;
        burst_u.fields.index = c_addr.fields.index;
        burst_u.fields.offset = word_index;
    end

    assign burst_addr = burst_u.word;
    assign burst_access = (state == dcache_pkg::st_write_back) || (state == dcache_pkg::st_fill);
    assign burst_write = (state == dcache_pkg::st_write_back);

endmodule

`default_nettype wire

// File: source/dcache_top.sv
// Data cache top level, joins the blocks and bypasses to memory when disabled
`default_nettype none
`timescale 1ns/1ps

module dcache_top (
    input wire logic clk,
    input wire logic reset,
    input wire logic enabled,

    // Processor port
    input wire logic [dcache_pkg::addr_bits-1:0] c_addr,
    input wire logic [dcache_pkg::data_bits-1:0] c_wdata,
    output logic [dcache_pkg::data_bits-1:0] c_rdata,
    input wire logic [dcache_pkg::bytesel_bits-1:0] c_bytesel,
    input wire logic c_wr_en,
    input wire logic c_access,
    output logic c_ack,

    // Memory port
    output logic [dcache_pkg::addr_bits-1:0] m_addr,
    output logic [dcache_pkg::data_bits-1:0] m_wdata,
    input wire logic [dcache_pkg::data_bits-1:0] m_rdata,
    output logic [dcache_pkg::bytesel_bits-1:0] m_bytesel,
    output logic m_wr_en,
    output logic m_access,
    input wire logic m_ack
);

    dcache_pkg::cache_addr_t c_addr_u;

    logic hit;
    logic [dcache_pkg::tag_bits-1:0] victim_tag;
    logic victim_dirty;
    logic [dcache_pkg::offset_bits-1:0] word_index;
    logic last_word;
    logic count_clear;
    logic count_step;
    logic tag_wr;
    logic valid_set;
    logic dirty_set;
    logic dirty_clear;
    logic line_wr_en_a;
    logic line_wr_en_b;
    logic [dcache_pkg::line_addr_bits-1:0] line_addr_b;
    logic [dcache_pkg::addr_bits-1:0] burst_addr;
    logic burst_access;
    logic burst_write;
    logic cache_ack;
    logic [dcache_pkg::data_bits-1:0] rdata_a;
    logic [dcache_pkg::data_bits-1:0] rdata_b;

    // Flat processor address split into tag, index and offset
    assign c_addr_u = c_addr;

    dcache_controller controller_inst (
        .clk(clk), .reset(reset), .enabled(enabled),
        .c_access(c_access), .c_wr_en(c_wr_en), .c_addr(c_addr_u),
        .hit(hit), .victim_tag(victim_tag), .victim_dirty(victim_dirty),
        .m_ack(m_ack), .last_word(last_word), .word_index(word_index),
        .count_clear(count_clear), .count_step(count_step),
        .tag_wr(tag_wr), .valid_set(valid_set), .dirty_set(dirty_set),
        .dirty_clear(dirty_clear), .line_wr_en_a(line_wr_en_a),
        .line_wr_en_b(line_wr_en_b), .line_addr_b(line_addr_b),
        .burst_addr(burst_addr), .burst_access(burst_access),
        .burst_write(burst_write), .ack(cache_ack)
    );

    dcache_word_counter word_counter_inst (
        .clk(clk), .reset(reset), .count_clear(count_clear),
        .count_step(count_step), .word_index(word_index), .last_word(last_word)
    );

    // Replacement always targets the line of the current request
    dcache_tag_store tag_store_inst (
        .clk(clk), .reset(reset), .lookup_addr(c_addr_u),
        .update_addr(c_addr_u.fields.index), .tag_wr(tag_wr),
        .tag_data(c_addr_u.fields.tag), .valid_set(valid_set),
        .dirty_clear(dirty_clear), .dirty_set_index(c_addr_u.fields.index),
        .dirty_set(dirty_set), .hit(hit), .victim_tag(victim_tag),
        .victim_dirty(victim_dirty)
    );

    dcache_line_ram line_ram_inst (
        .clk(clk),
        .addr_a({c_addr_u.fields.index, c_addr_u.fields.offset}),
        .wdata_a(c_wdata), .bytesel_a(c_bytesel), .wr_en_a(line_wr_en_a),
        .rdata_a(rdata_a),
        .addr_b(line_addr_b), .wdata_b(m_rdata), .wr_en_b(line_wr_en_b),
        .rdata_b(rdata_b)
    );

    // Bypass hands the processor port straight to memory
    assign c_ack = enabled ? cache_ack : m_ack;
    assign c_rdata = enabled ? rdata_a : m_rdata;
    assign m_addr = enabled ? burst_addr : c_addr;
    assign m_wdata = enabled ? rdata_b : c_wdata;
    assign m_wr_en = enabled ? burst_write : c_wr_en;
    assign m_access = enabled ? burst_access : c_access;
    // Line bursts always move whole words
    assign m_bytesel = enabled ? {dcache_pkg::bytesel_bits{1'b1}} : c_bytesel;

endmodule

`default_nettype wire

// File: dv/dcache_checker.sv
// Protocol assertions for the data cache, bound into every dcache_top instance
`default_nettype none
`timescale 1ns/1ps

module dcache_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic enabled,
    input wire logic c_access,
    input wire logic c_ack,
    input wire logic m_access,
    input wire logic m_wr_en,
    input wire logic m_ack,
    input wire logic [dcache_pkg::offset_bits-1:0] m_offset
);

    // Ack only answers a request that is still held
    ack_needs_access: assert property (@(posedge clk) disable iff (reset) c_ack |-> c_access)
        else $error("c_ack raised without c_access");

    write_needs_access: assert property (@(posedge clk) disable iff (reset) m_wr_en |-> m_access)
        else $error("m_wr_en raised without m_access");

    quiet_in_reset: assert property (@(posedge clk) reset |-> (!c_ack && !m_access))
        else $error("c_ack or m_access active during reset");

    // Bursts open on word 0 of a line
    burst_starts_aligned: assert property (@(posedge clk) disable iff (reset)
        (enabled && $rose(m_access)) |-> (m_offset == '0))
        else $error("Cache burst started off a line boundary");

    // Each memory ack moves the burst one word up, wrapping at the line end
    burst_steps_upward: assert property (@(posedge clk) disable iff (reset)
        (enabled && m_access && m_ack) |=>
        (!m_access || m_offset == $past(m_offset) + dcache_pkg::offset_bits'(1)))
        else $error("Cache burst offset did not step upward");

    no_access_when_idle: assert property (@(posedge clk) disable iff (reset)
        (enabled && !c_access) |-> !m_access)
        else $error("Memory accessed with no processor request");

endmodule

bind dcache_top dcache_checker checker_inst (
    .clk(clk), .reset(reset), .enabled(enabled), .c_access(c_access), .c_ack(c_ack),
    .m_access(m_access), .m_wr_en(m_wr_en), .m_ack(m_ack),
    .m_offset(m_addr[dcache_pkg::offset_bits-1:0])
);

`default_nettype wire

// File: dv/dcache_tb.sv
// Data cache testbench running directed and LFSR-driven accesses against a memory model
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;

    localparam int num_tests = 5;
    localparam int mem_words = 2 ** dcache_pkg::addr_bits;

    logic clk = 1'b0;
    logic reset;
    logic enabled;
    logic [dcache_pkg::addr_bits-1:0] c_addr;
    logic [dcache_pkg::addr_bits-1:0] m_addr;
    logic [dcache_pkg::data_bits-1:0] c_wdata;
    logic [dcache_pkg::data_bits-1:0] c_rdata;
    logic [dcache_pkg::data_bits-1:0] m_wdata;
    logic [dcache_pkg::data_bits-1:0] m_rdata;
    logic [dcache_pkg::bytesel_bits-1:0] c_bytesel;
    logic [dcache_pkg::bytesel_bits-1:0] m_bytesel;
    logic c_wr_en;
    logic c_access;
    logic c_ack;
    logic m_wr_en;
    logic m_access;
    logic m_ack;

    // Memory contents and the processor's expected view of them
    logic [15:0] mem_model [mem_words];
    logic [15:0] ref_mem [mem_words];
    logic [15:0] stim_lfsr = 16'd52130;
    logic [15:0] mem_lfsr = 16'd52130;

    int cycle_count = 0;
    int total_acks = 0;
    int total_writes = 0;
    int monitor_errors = 0;
    int read_checks = 0;
    int check_errors = 0;
    int value_checks = 0;
    int tests_done = 0;
    int last_latency;
    int acks_seen;
    int writes_seen;

    dcache_top dcache_top_inst (
        .clk(clk), .reset(reset), .enabled(enabled), .c_addr(c_addr), .c_wdata(c_wdata),
        .c_rdata(c_rdata), .c_bytesel(c_bytesel), .c_wr_en(c_wr_en), .c_access(c_access),
        .c_ack(c_ack), .m_addr(m_addr), .m_wdata(m_wdata), .m_rdata(m_rdata),
        .m_bytesel(m_bytesel), .m_wr_en(m_wr_en), .m_access(m_access), .m_ack(m_ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Galois LFSR with taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(inout logic [15:0] state, input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_step(state);
            value = (value << 1) | int'(state[0]);
        end
    endtask

    // Every address bit reaches the pattern
    function automatic logic [15:0] fill_pattern(input int addr);
        return 16'(addr ^ (addr >> 3)) ^ 16'h5A3C;
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] data, input logic [1:0] sel);
        return {sel[1] ? data[15:8] : old[15:8], sel[0] ? data[7:0] : old[7:0]};
    endfunction

    function automatic logic [dcache_pkg::addr_bits-1:0] make_addr(input int tag, input int index,
                                                                   input int offset);
        dcache_pkg::cache_addr_t a;
        a.fields.tag = dcache_pkg::tag_bits'(tag);
        a.fields.index = dcache_pkg::index_bits'(index);
        a.fields.offset = dcache_pkg::offset_bits'(offset);
        return a.word;
    endfunction

    // Memory answers each access after 1 to 4 cycles
    initial begin : memory_model
        int wait_cycles;
        m_ack = 1'b0;
        m_rdata = '0;
        for (int a = 0; a < mem_words; a++) begin
            mem_model[a] = fill_pattern(a);
        end
        forever begin
            @(negedge clk);
            if (m_access) begin
                take_bits(mem_lfsr, 2, wait_cycles);
                repeat (wait_cycles + 1) @(posedge clk);
                #5;
                if (m_wr_en) begin
                    mem_model[m_addr] = merge_bytes(mem_model[m_addr], m_wdata, m_bytesel);
                end else begin
                    m_rdata = mem_model[m_addr];
                end
                m_ack = 1'b1;
                @(posedge clk);
                #5;
                m_ack = 1'b0;
            end
        end
    end

    // Mid-cycle monitor where all outputs have settled
    always @(negedge clk) begin
        if (!reset) begin
            if (m_ack) begin
                total_acks <= total_acks + 1;
                total_writes <= total_writes + int'(m_wr_en);
            end
            if (c_ack && !c_wr_en) begin
                read_checks <= read_checks + 1;
                assert (c_rdata == ref_mem[c_addr]) else begin
                    $display("MISMATCH c_rdata at 0x%h expected 0x%h actual 0x%h",
                             c_addr, ref_mem[c_addr], c_rdata);
                    monitor_errors <= monitor_errors + 1;
                end
            end
            // Bypass hands every processor signal to memory unchanged
            if (!enabled && c_access) begin
                check_value("m_addr", int'(c_addr), int'(m_addr));
                check_value("m_wdata", int'(c_wdata), int'(m_wdata));
                check_value("m_bytesel", int'(c_bytesel), int'(m_bytesel));
                check_value("m_wr_en", int'(c_wr_en), int'(m_wr_en));
                check_value("m_access", 1, int'(m_access));
                check_value("c_ack", int'(m_ack), int'(c_ack));
            end
        end
    end

    // Called 5 ns after a rising edge and returns at the same point after the ack
    task automatic cpu_access(input logic write, input logic [dcache_pkg::addr_bits-1:0] addr,
                              input logic [15:0] data, input logic [1:0] sel);
        int start_cycle;
        int start_acks;
        int start_writes;
        start_cycle = cycle_count;
        start_acks = total_acks;
        start_writes = total_writes;
        c_addr = addr;
        c_wdata = data;
        c_bytesel = sel;
        c_wr_en = write;
        c_access = 1'b1;
        @(negedge clk);
        while (!c_ack) @(negedge clk);
        // Latency counted from the edge that first sees the request
        last_latency = cycle_count - start_cycle - 1;
        if (write) begin
            ref_mem[addr] = merge_bytes(ref_mem[addr], data, sel);
        end
        @(posedge clk);
        #5;
        c_access = 1'b0;
        c_wr_en = 1'b0;
        acks_seen = total_acks - start_acks;
        writes_seen = total_writes - start_writes;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        value_checks++;
        assert (expected == actual) else begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_done++;
        $display("test %0d %s finished with %0d errors", tests_done, name,
                 check_errors + monitor_errors - errors_before);
    endtask

    initial begin : stimulus
        int errors_before;
        int tag;
        int index;
        int offset;
        int write;
        int sel;
        int data;
        reset = 1'b1;
        enabled = 1'b1;
        c_addr = '0;
        c_wdata = '0;
        c_bytesel = '0;
        c_wr_en = 1'b0;
        c_access = 1'b0;
        for (int a = 0; a < mem_words; a++) begin
            ref_mem[a] = fill_pattern(a);
        end
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;
        @(posedge clk);
        #5;

        // Clean victims with each line fetched as one 8-word burst
        errors_before = check_errors + monitor_errors;
        for (int i = 0; i < 3; i++) begin
            cpu_access(1'b0, make_addr(0, i, i + 2), '0, 2'b00);
            check_value("cold miss m_ack count", 8, acks_seen);
            check_value("cold miss write count", 0, writes_seen);
        end
        finish_test("cold_read_miss", errors_before);

        // Byte writes into a resident line and then read hits on the merged words
        errors_before = check_errors + monitor_errors;
        cpu_access(1'b1, make_addr(0, 1, 3), 16'hBEEF, 2'b01);
        check_value("write hit latency", 2, last_latency);
        cpu_access(1'b0, make_addr(0, 1, 3), '0, 2'b00);
        check_value("read hit latency", 2, last_latency);
        check_value("read hit m_ack count", 0, acks_seen);
        cpu_access(1'b1, make_addr(0, 1, 6), 16'hC3A5, 2'b10);
        cpu_access(1'b0, make_addr(0, 1, 6), '0, 2'b00);
        check_value("read hit latency", 2, last_latency);
        finish_test("write_hit_bytes", errors_before);

        // Other tag on the dirty index sends the line out before the new one comes in
        errors_before = check_errors + monitor_errors;
        cpu_access(1'b0, make_addr(5, 1, 0), '0, 2'b00);
        check_value("dirty miss m_ack count", 16, acks_seen);
        check_value("write-back word count", 8, writes_seen);
        check_value("written-back word", int'(ref_mem[make_addr(0, 1, 3)]),
                    int'(mem_model[make_addr(0, 1, 3)]));
        cpu_access(1'b0, make_addr(0, 1, 3), '0, 2'b00);
        check_value("refill m_ack count", 8, acks_seen);
        finish_test("dirty_write_back", errors_before);

        // Cache disabled so single-word transfers go straight to memory
        errors_before = check_errors + monitor_errors;
        enabled = 1'b0;
        cpu_access(1'b1, make_addr(10'h3FF, 9, 4), 16'h1234, 2'b11);
        check_value("bypass write m_ack count", 1, acks_seen);
        check_value("bypass memory word", 16'h1234, int'(mem_model[make_addr(10'h3FF, 9, 4)]));
        cpu_access(1'b0, make_addr(10'h3FF, 9, 4), '0, 2'b00);
        check_value("bypass read m_ack count", 1, acks_seen);
        enabled = 1'b1;
        finish_test("bypass", errors_before);

        // Two tags over four indices keep lines colliding
        errors_before = check_errors + monitor_errors;
        for (int i = 0; i < 16; i++) begin
            take_bits(stim_lfsr, 1, tag);
            take_bits(stim_lfsr, 2, index);
            take_bits(stim_lfsr, 3, offset);
            take_bits(stim_lfsr, 1, write);
            take_bits(stim_lfsr, 2, sel);
            take_bits(stim_lfsr, 16, data);
            cpu_access(1'(write), make_addr(tag, index, offset), 16'(data), 2'(sel));
        end
        finish_test("random_mix", errors_before);

        $display("tests %0d, checks %0d, errors %0d", tests_done, value_checks + read_checks,
                 check_errors + monitor_errors);
        if (check_errors + monitor_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (num_tests * 400) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a request never completed", num_tests * 400);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/dcache_pkg.sv
source/dcache_line_ram.sv
source/dcache_tag_store.sv
source/dcache_word_counter.sv
source/dcache_controller.sv
source/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module dcache_tb -Mdir obj_dir -o dcache_sim \
    -f build.f || { echo "Verilator build failed"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
